// File: design/axil_pkg.sv
`default_nettype none

package axil_pkg;

   // Byte address and data widths
   parameter int ADDR_W = 12;
   parameter int DATA_W = 32;
   parameter int STRB_W = DATA_W / 8;    // One strobe per byte lane

   // Response codes on bresp and rresp
   parameter logic [1:0] RESP_OKAY   = 2'b00;
   parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// File: design/soc_cfg_pkg.sv
`default_nettype none

package soc_cfg_pkg;

   // Reset pulse timing, in clk_i cycles
   parameter int RST_START_DFLT    = 5;    // External release to pulse start
   parameter int RST_DURATION_DFLT = 10;   // Pulse length

   parameter int MEM_WORDS_DFLT = 256;     // Byte addresses 0 to 1023

endpackage

`default_nettype wire

// File: design/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
   parameter int START    = soc_cfg_pkg::RST_START_DFLT,
   parameter int DURATION = soc_cfg_pkg::RST_DURATION_DFLT
) (
   input  logic clk_i,
   input  logic rst_n_i,
   output logic sys_rst_o
);

   localparam int CNT_MAX = START + DURATION;
   localparam int CNT_W   = $clog2(CNT_MAX + 1);

   logic [CNT_W-1:0] cnt_q;   // Cycles since external release

   // Counter stops at the end of the pulse
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (cnt_q != CNT_W'(CNT_MAX)) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Pulse window from START to START plus DURATION
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         sys_rst_o <= 1'b0;
      end else if (cnt_q == CNT_W'(CNT_MAX)) begin
         sys_rst_o <= 1'b0;
      end else if (cnt_q == CNT_W'(START)) begin
         sys_rst_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: design/axil_two_port_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module axil_two_port_arbiter (
   input  logic                        clk_i,
   input  logic                        sys_rst_i,
   input  logic                        rst_n_i,
   // System port
   input  logic [axil_pkg::ADDR_W-1:0] s0_awaddr_i,
   input  logic                        s0_awvalid_i,
   output logic                        s0_awready_o,
   input  logic [axil_pkg::DATA_W-1:0] s0_wdata_i,
   input  logic [axil_pkg::STRB_W-1:0] s0_wstrb_i,
   input  logic                        s0_wvalid_i,
   output logic                        s0_wready_o,
   output logic [1:0]                  s0_bresp_o,
   output logic                        s0_bvalid_o,
   input  logic                        s0_bready_i,
   input  logic [axil_pkg::ADDR_W-1:0] s0_araddr_i,
   input  logic                        s0_arvalid_i,
   output logic                        s0_arready_o,
   output logic [axil_pkg::DATA_W-1:0] s0_rdata_o,
   output logic [1:0]                  s0_rresp_o,
   output logic                        s0_rvalid_o,
   input  logic                        s0_rready_i,
   // Tester port
   input  logic [axil_pkg::ADDR_W-1:0] s1_awaddr_i,
   input  logic                        s1_awvalid_i,
   output logic                        s1_awready_o,
   input  logic [axil_pkg::DATA_W-1:0] s1_wdata_i,
   input  logic [axil_pkg::STRB_W-1:0] s1_wstrb_i,
   input  logic                        s1_wvalid_i,
   output logic                        s1_wready_o,
   output logic [1:0]                  s1_bresp_o,
   output logic                        s1_bvalid_o,
   input  logic                        s1_bready_i,
   input  logic [axil_pkg::ADDR_W-1:0] s1_araddr_i,
   input  logic                        s1_arvalid_i,
   output logic                        s1_arready_o,
   output logic [axil_pkg::DATA_W-1:0] s1_rdata_o,
   output logic [1:0]                  s1_rresp_o,
   output logic                        s1_rvalid_o,
   input  logic                        s1_rready_i,
   // Memory side
   output logic [axil_pkg::ADDR_W-1:0] m_awaddr_o,
   output logic                        m_awvalid_o,
   input  logic                        m_awready_i,
   output logic [axil_pkg::DATA_W-1:0] m_wdata_o,
   output logic [axil_pkg::STRB_W-1:0] m_wstrb_o,
   output logic                        m_wvalid_o,
   input  logic                        m_wready_i,
   input  logic [1:0]                  m_bresp_i,
   input  logic                        m_bvalid_i,
   output logic                        m_bready_o,
   output logic [axil_pkg::ADDR_W-1:0] m_araddr_o,
   output logic                        m_arvalid_o,
   input  logic                        m_arready_i,
   input  logic [axil_pkg::DATA_W-1:0] m_rdata_i,
   input  logic [1:0]                  m_rresp_i,
   input  logic                        m_rvalid_i,
   output logic                        m_rready_o
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_WR   = 2'd1;
   localparam logic [1:0] ST_RD   = 2'd2;

   logic [1:0] state_q, state_d;
   logic       last_q, last_d;   // Port served last, holds the grant outside idle
   logic       s0_wr_req, s1_wr_req;
   logic       s0_req, s1_req;
   logic       idle, pick, sel, sel_wr, active, wr_go, rd_go;

   assign s0_wr_req = s0_awvalid_i && s0_wvalid_i;   // Write needs AW and W together
   assign s1_wr_req = s1_awvalid_i && s1_wvalid_i;
   assign s0_req    = s0_wr_req || s0_arvalid_i;
   assign s1_req    = s1_wr_req || s1_arvalid_i;

   // On a tie the port not served last wins
   assign pick   = (s0_req && s1_req) ? ~last_q : s1_req;
   assign idle   = (state_q == ST_IDLE);
   assign sel    = idle ? pick : last_q;
   assign sel_wr = idle ? (pick ? s1_wr_req : s0_wr_req) : (state_q == ST_WR);
   assign active = rst_n_i && !sys_rst_i && (!idle || s0_req || s1_req);   // Nothing passes in reset
   assign wr_go  = active && sel_wr;
   assign rd_go  = active && !sel_wr;

   // Granted port towards the memory
   assign m_awaddr_o  = sel ? s1_awaddr_i : s0_awaddr_i;
   assign m_awvalid_o = wr_go && (sel ? s1_awvalid_i : s0_awvalid_i);
   assign m_wdata_o   = sel ? s1_wdata_i : s0_wdata_i;
   assign m_wstrb_o   = sel ? s1_wstrb_i : s0_wstrb_i;
   assign m_wvalid_o  = wr_go && (sel ? s1_wvalid_i : s0_wvalid_i);
   assign m_bready_o  = wr_go && (sel ? s1_bready_i : s0_bready_i);
   assign m_araddr_o  = sel ? s1_araddr_i : s0_araddr_i;
   assign m_arvalid_o = rd_go && (sel ? s1_arvalid_i : s0_arvalid_i);
   assign m_rready_o  = rd_go && (sel ? s1_rready_i : s0_rready_i);

   // Handshakes back to the ports, losing port sees all low
   assign s0_awready_o = wr_go && !sel && m_awready_i;
   assign s0_wready_o  = wr_go && !sel && m_wready_i;
   assign s0_bvalid_o  = wr_go && !sel && m_bvalid_i;
   assign s0_arready_o = rd_go && !sel && m_arready_i;
   assign s0_rvalid_o  = rd_go && !sel && m_rvalid_i;
   assign s1_awready_o = wr_go && sel && m_awready_i;
   assign s1_wready_o  = wr_go && sel && m_wready_i;
   assign s1_bvalid_o  = wr_go && sel && m_bvalid_i;
   assign s1_arready_o = rd_go && sel && m_arready_i;
   assign s1_rvalid_o  = rd_go && sel && m_rvalid_i;

   assign s0_bresp_o = m_bresp_i;
   assign s1_bresp_o = m_bresp_i;
   assign s0_rdata_o = m_rdata_i;
   assign s1_rdata_o = m_rdata_i;
   assign s0_rresp_o = m_rresp_i;
   assign s1_rresp_o = m_rresp_i;

   always_comb begin
      state_d = state_q;
      last_d  = last_q;
      case (state_q)
         ST_IDLE: begin
            if (s0_req || s1_req) begin
               state_d = sel_wr ? ST_WR : ST_RD;
               last_d  = pick;
            end
         end
         ST_WR: if (m_bvalid_i && m_bready_o) state_d = ST_IDLE;   // Held until B
         ST_RD: if (m_rvalid_i && m_rready_o) state_d = ST_IDLE;   // Held until R
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sys_rst_i) begin
         state_q <= ST_IDLE;
         last_q  <= 1'b0;   // Port 1 takes the first tie
      end else begin
         state_q <= state_d;
         last_q  <= last_d;
      end
   end

endmodule

`default_nettype wire

// File: design/axil_sram.sv
`timescale 1ns/10ps
`default_nettype none

module axil_sram #(
   parameter int MEM_WORDS = soc_cfg_pkg::MEM_WORDS_DFLT
) (
   input  logic                        clk_i,
   input  logic                        sys_rst_i,
   input  logic                        rst_n_i,
   input  logic [axil_pkg::ADDR_W-1:0] awaddr_i,
   input  logic                        awvalid_i,
   output logic                        awready_o,
   input  logic [axil_pkg::DATA_W-1:0] wdata_i,
   input  logic [axil_pkg::STRB_W-1:0] wstrb_i,
   input  logic                        wvalid_i,
   output logic                        wready_o,
   output logic [1:0]                  bresp_o,
   output logic                        bvalid_o,
   input  logic                        bready_i,
   input  logic [axil_pkg::ADDR_W-1:0] araddr_i,
   input  logic                        arvalid_i,
   output logic                        arready_o,
   output logic [axil_pkg::DATA_W-1:0] rdata_o,
   output logic [1:0]                  rresp_o,
   output logic                        rvalid_o,
   input  logic                        rready_i
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [axil_pkg::DATA_W-1:0] mem [MEM_WORDS];
   logic                        en;   // Low while either reset is active
   logic                        busy, wr_acc, rd_acc, aw_ok, ar_ok;
   logic [IDX_W-1:0]            aw_idx, ar_idx;

   // Word index from the byte address, low two bits ignored
   assign aw_idx = awaddr_i[2 +: IDX_W];
   assign ar_idx = araddr_i[2 +: IDX_W];
   assign aw_ok  = int'(awaddr_i[axil_pkg::ADDR_W-1:2]) < MEM_WORDS;
   assign ar_ok  = int'(araddr_i[axil_pkg::ADDR_W-1:2]) < MEM_WORDS;

   assign en     = rst_n_i && !sys_rst_i;
   assign busy   = bvalid_o || rvalid_o;   // One response outstanding at most
   assign wr_acc = en && !busy && awvalid_i && wvalid_i;
   assign rd_acc = en && !busy && arvalid_i && !(awvalid_i && wvalid_i);

   assign awready_o = wr_acc;
   assign wready_o  = wr_acc;
   assign arready_o = rd_acc;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sys_rst_i) begin
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         if (wr_acc) bvalid_o <= 1'b1;
         else if (bready_i) bvalid_o <= 1'b0;
         if (rd_acc) rvalid_o <= 1'b1;
         else if (rready_i) rvalid_o <= 1'b0;
      end
   end

   // Byte merge, out of range writes leave memory untouched
   always_ff @(posedge clk_i) begin
      if (wr_acc && aw_ok) begin
         for (int b = 0; b < axil_pkg::STRB_W; b++) begin
            if (wstrb_i[b]) mem[aw_idx][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

   // Response payload held until the transfer
   always_ff @(posedge clk_i) begin
      if (wr_acc) bresp_o <= aw_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      if (rd_acc) begin
         rdata_o <= ar_ok ? mem[ar_idx] : '0;
         rresp_o <= ar_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
      end
   end

endmodule

`default_nettype wire

// File: design/soc_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_mem_top #(
   parameter int START     = soc_cfg_pkg::RST_START_DFLT,
   parameter int DURATION  = soc_cfg_pkg::RST_DURATION_DFLT,
   parameter int MEM_WORDS = soc_cfg_pkg::MEM_WORDS_DFLT
) (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // System port
   input  logic [axil_pkg::ADDR_W-1:0] s0_awaddr_i,
   input  logic                        s0_awvalid_i,
   output logic                        s0_awready_o,
   input  logic [axil_pkg::DATA_W-1:0] s0_wdata_i,
   input  logic [axil_pkg::STRB_W-1:0] s0_wstrb_i,
   input  logic                        s0_wvalid_i,
   output logic                        s0_wready_o,
   output logic [1:0]                  s0_bresp_o,
   output logic                        s0_bvalid_o,
   input  logic                        s0_bready_i,
   input  logic [axil_pkg::ADDR_W-1:0] s0_araddr_i,
   input  logic                        s0_arvalid_i,
   output logic                        s0_arready_o,
   output logic [axil_pkg::DATA_W-1:0] s0_rdata_o,
   output logic [1:0]                  s0_rresp_o,
   output logic                        s0_rvalid_o,
   input  logic                        s0_rready_i,
   // Tester port
   input  logic [axil_pkg::ADDR_W-1:0] s1_awaddr_i,
   input  logic                        s1_awvalid_i,
   output logic                        s1_awready_o,
   input  logic [axil_pkg::DATA_W-1:0] s1_wdata_i,
   input  logic [axil_pkg::STRB_W-1:0] s1_wstrb_i,
   input  logic                        s1_wvalid_i,
   output logic                        s1_wready_o,
   output logic [1:0]                  s1_bresp_o,
   output logic                        s1_bvalid_o,
   input  logic                        s1_bready_i,
   input  logic [axil_pkg::ADDR_W-1:0] s1_araddr_i,
   input  logic                        s1_arvalid_i,
   output logic                        s1_arready_o,
   output logic [axil_pkg::DATA_W-1:0] s1_rdata_o,
   output logic [1:0]                  s1_rresp_o,
   output logic                        s1_rvalid_o,
   input  logic                        s1_rready_i,
   output logic                        sys_rst_o
);

   // Arbiter to memory
   logic [axil_pkg::ADDR_W-1:0] m_awaddr, m_araddr;
   logic [axil_pkg::DATA_W-1:0] m_wdata, m_rdata;
   logic [axil_pkg::STRB_W-1:0] m_wstrb;
   logic [1:0]                  m_bresp, m_rresp;
   logic                        m_awvalid, m_awready, m_wvalid, m_wready;
   logic                        m_bvalid, m_bready, m_arvalid, m_arready;
   logic                        m_rvalid, m_rready;

   reset_sequencer #(
      .START    (START),
      .DURATION (DURATION)
   ) u_rst_seq (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .sys_rst_o (sys_rst_o)
   );

   // Port sets share names with the top level
   axil_two_port_arbiter u_arb (
      .sys_rst_i   (sys_rst_o),
      .m_awaddr_o  (m_awaddr),
      .m_awvalid_o (m_awvalid),
      .m_awready_i (m_awready),
      .m_wdata_o   (m_wdata),
      .m_wstrb_o   (m_wstrb),
      .m_wvalid_o  (m_wvalid),
      .m_wready_i  (m_wready),
      .m_bresp_i   (m_bresp),
      .m_bvalid_i  (m_bvalid),
      .m_bready_o  (m_bready),
      .m_araddr_o  (m_araddr),
      .m_arvalid_o (m_arvalid),
      .m_arready_i (m_arready),
      .m_rdata_i   (m_rdata),
      .m_rresp_i   (m_rresp),
      .m_rvalid_i  (m_rvalid),
      .m_rready_o  (m_rready),
      .*
   );

   axil_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_sram (
      .clk_i     (clk_i),
      .sys_rst_i (sys_rst_o),
      .rst_n_i   (rst_n_i),
      .awaddr_i  (m_awaddr),
      .awvalid_i (m_awvalid),
      .awready_o (m_awready),
      .wdata_i   (m_wdata),
      .wstrb_i   (m_wstrb),
      .wvalid_i  (m_wvalid),
      .wready_o  (m_wready),
      .bresp_o   (m_bresp),
      .bvalid_o  (m_bvalid),
      .bready_i  (m_bready),
      .araddr_i  (m_araddr),
      .arvalid_i (m_arvalid),
      .arready_o (m_arready),
      .rdata_o   (m_rdata),
      .rresp_o   (m_rresp),
      .rvalid_o  (m_rvalid),
      .rready_i  (m_rready)
   );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD_NS = 40
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2) clk_o = ~clk_o;   // Even duty cycle

endmodule

`default_nettype wire

// File: verification/soc_mem_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module soc_mem_asserts (
   input logic                        clk_i,
   input logic                        rst_n_i,
   input logic                        sys_rst_i,
   input logic [axil_pkg::ADDR_W-1:0] s0_awaddr_i,
   input logic                        s0_awvalid_i,
   input logic                        s0_awready_i,
   input logic [axil_pkg::ADDR_W-1:0] s1_awaddr_i,
   input logic                        s1_awvalid_i,
   input logic                        s1_awready_i,
   input logic                        s0_arready_i,
   input logic                        s1_arready_i,
   input logic [1:0]                  m_bresp_i,
   input logic                        m_bvalid_i,
   input logic                        m_bready_i,
   input logic [axil_pkg::DATA_W-1:0] m_rdata_i,
   input logic                        m_rvalid_i,
   input logic                        m_rready_i
);

   logic pulse_seen_q;   // Reset pulse has been high at least once
   logic held_q;         // Accepted request still waiting for its response
   logic any_acc;

   assign any_acc = s0_awready_i || s1_awready_i || s0_arready_i || s1_arready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pulse_seen_q <= 1'b0;
      end else if (sys_rst_i) begin
         pulse_seen_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || sys_rst_i) begin
         held_q <= 1'b0;
      end else if ((m_bvalid_i && m_bready_i) || (m_rvalid_i && m_rready_i)) begin
         held_q <= 1'b0;
      end else if (any_acc) begin
         held_q <= 1'b1;
      end
   end

   a_aw0_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || sys_rst_i)
      s0_awvalid_i && !s0_awready_i |=> s0_awvalid_i && $stable(s0_awaddr_i))
      else $error("Port 0 AW request changed before its transfer");

   a_aw1_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || sys_rst_i)
      s1_awvalid_i && !s1_awready_i |=> s1_awvalid_i && $stable(s1_awaddr_i))
      else $error("Port 1 AW request changed before its transfer");

   // Stalled responses keep their payload
   a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || sys_rst_i)
      m_bvalid_i && !m_bready_i |=> m_bvalid_i && $stable(m_bresp_i))
      else $error("B response changed while stalled");

   a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || sys_rst_i)
      m_rvalid_i && !m_rready_i |=> m_rvalid_i && $stable(m_rdata_i))
      else $error("R response changed while stalled");

   // Other port waits until the granted response has transferred
   a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(s0_awready_i && s1_awready_i) && !(s0_arready_i && s1_arready_i)
      && !(held_q && any_acc))
      else $error("A request was accepted while another one was still outstanding");

   a_pulse_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pulse_seen_q && !sys_rst_i |=> !sys_rst_i)
      else $error("System reset rose again after the pulse");

endmodule

bind axil_two_port_arbiter soc_mem_asserts u_asserts (
   .s0_awready_i (s0_awready_o),
   .s1_awready_i (s1_awready_o),
   .s0_arready_i (s0_arready_o),
   .s1_arready_i (s1_arready_o),
   .m_bready_i   (m_bready_o),
   .m_rready_i   (m_rready_o),
   .*
);

`default_nettype wire

// File: verification/tb_soc_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_mem;

   localparam int RST_START = soc_cfg_pkg::RST_START_DFLT;
   localparam int RST_DUR   = soc_cfg_pkg::RST_DURATION_DFLT;
   localparam int WORDS     = soc_cfg_pkg::MEM_WORDS_DFLT;
   localparam int N_SINGLE  = 16;
   localparam int N_STRB    = 8;
   localparam int N_DUAL    = 24;   // Per port, one write and one read each
   localparam int N_OOR     = 4;
   localparam int N_TXN     = 1 + 2 * WORDS + 2 * N_SINGLE + 2 * N_STRB + 4 * N_DUAL + 3 * N_OOR;
   localparam logic [axil_pkg::ADDR_W-1:0] SHARED_ADDR = 12'h3f0;

   logic                        clk;
   logic                        rst_n;
   logic                        sys_rst;
   logic [axil_pkg::ADDR_W-1:0] awaddr [2];
   logic                        awvalid [2];
   logic                        awready [2];
   logic [axil_pkg::DATA_W-1:0] wdata [2];
   logic [axil_pkg::STRB_W-1:0] wstrb [2];
   logic                        wvalid [2];
   logic                        wready [2];
   logic [1:0]                  bresp [2];
   logic                        bvalid [2];
   logic                        bready [2];
   logic [axil_pkg::ADDR_W-1:0] araddr [2];
   logic                        arvalid [2];
   logic                        arready [2];
   logic [axil_pkg::DATA_W-1:0] rdata [2];
   logic [1:0]                  rresp [2];
   logic                        rvalid [2];
   logic                        rready [2];

   logic [axil_pkg::DATA_W-1:0] model [WORDS];   // Reference copy of the memory
   logic [axil_pkg::ADDR_W-1:0] pend_addr [2];   // Request waiting for its response
   logic [axil_pkg::DATA_W-1:0] pend_data [2];
   logic [axil_pkg::STRB_W-1:0] pend_strb [2];
   logic                        pend_wr [2];
   int                          stall_max;
   int                          issued;
   int                          completed;

   tb_clock_gen #(.PERIOD_NS(40)) u_clk_gen (.clk_o(clk));

   soc_mem_top DUT (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .s0_awaddr_i  (awaddr[0]),
      .s0_awvalid_i (awvalid[0]),
      .s0_awready_o (awready[0]),
      .s0_wdata_i   (wdata[0]),
      .s0_wstrb_i   (wstrb[0]),
      .s0_wvalid_i  (wvalid[0]),
      .s0_wready_o  (wready[0]),
      .s0_bresp_o   (bresp[0]),
      .s0_bvalid_o  (bvalid[0]),
      .s0_bready_i  (bready[0]),
      .s0_araddr_i  (araddr[0]),
      .s0_arvalid_i (arvalid[0]),
      .s0_arready_o (arready[0]),
      .s0_rdata_o   (rdata[0]),
      .s0_rresp_o   (rresp[0]),
      .s0_rvalid_o  (rvalid[0]),
      .s0_rready_i  (rready[0]),
      .s1_awaddr_i  (awaddr[1]),
      .s1_awvalid_i (awvalid[1]),
      .s1_awready_o (awready[1]),
      .s1_wdata_i   (wdata[1]),
      .s1_wstrb_i   (wstrb[1]),
      .s1_wvalid_i  (wvalid[1]),
      .s1_wready_o  (wready[1]),
      .s1_bresp_o   (bresp[1]),
      .s1_bvalid_o  (bvalid[1]),
      .s1_bready_i  (bready[1]),
      .s1_araddr_i  (araddr[1]),
      .s1_arvalid_i (arvalid[1]),
      .s1_arready_o (arready[1]),
      .s1_rdata_o   (rdata[1]),
      .s1_rresp_o   (rresp[1]),
      .s1_rvalid_o  (rvalid[1]),
      .s1_rready_i  (rready[1]),
      .sys_rst_o    (sys_rst)
   );

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
         $display("Test FAILED");
         $fatal(1, "Mismatch");
      end
   endtask

   // Expected {resp, data} of a read
   function automatic logic [axil_pkg::DATA_W+1:0] ref_read(input logic [11:0] addr);
      int idx;
      idx = int'(addr) / 4;
      if (idx >= WORDS) return {axil_pkg::RESP_SLVERR, 32'h0};
      return {axil_pkg::RESP_OKAY, model[idx]};
   endfunction

   // Strobe merge into the model, returns the expected bresp
   function automatic logic [1:0] apply_write(input logic [11:0] addr, input logic [31:0] data,
                                               input logic [3:0] strb);
      int idx;
      idx = int'(addr) / 4;
      if (idx >= WORDS) return axil_pkg::RESP_SLVERR;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) model[idx][8*b +: 8] = data[8*b +: 8];
      end
      return axil_pkg::RESP_OKAY;
   endfunction

   function automatic logic any_handshake();
      logic v;
      v = 1'b0;
      for (int p = 0; p < 2; p++) begin
         v = v | awready[p] | wready[p] | arready[p] | bvalid[p] | rvalid[p];
      end
      return v;
   endfunction

   // Compare process, every B and R transfer seen one half cycle before its edge
   always @(negedge clk) begin
      logic [axil_pkg::DATA_W+1:0] exp_r;
      for (int p = 0; p < 2; p++) begin
         if (bvalid[p] && bready[p]) begin
            check_value(pend_wr[p], 1'b1, $sformatf("port %0d B without a write", p));
            check_value(bresp[p], apply_write(pend_addr[p], pend_data[p], pend_strb[p]),
                        $sformatf("port %0d bresp", p));
            completed++;
         end
         if (rvalid[p] && rready[p]) begin
            exp_r = ref_read(pend_addr[p]);
            check_value(pend_wr[p], 1'b0, $sformatf("port %0d R without a read", p));
            check_value(rresp[p], exp_r[33:32], $sformatf("port %0d rresp", p));
            check_value(rdata[p], exp_r[31:0], $sformatf("port %0d rdata", p));
            completed++;
         end
      end
   end

   task automatic take_response(input int p, input bit is_wr);
      do @(negedge clk); while (!(is_wr ? bvalid[p] : rvalid[p]));
      repeat ($urandom_range(stall_max, 0)) @(negedge clk);   // Back-pressure stretch
      @(posedge clk);
      if (is_wr) bready[p] <= 1'b1;
      else rready[p] <= 1'b1;
      @(posedge clk);
      if (is_wr) bready[p] <= 1'b0;
      else rready[p] <= 1'b0;
   endtask

   task automatic write_access(input int p, input logic [11:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
      pend_addr[p] = addr;
      pend_data[p] = data;
      pend_strb[p] = strb;
      pend_wr[p]   = 1'b1;
      issued++;
      @(posedge clk);
      awaddr[p]  <= addr;
      wdata[p]   <= data;
      wstrb[p]   <= strb;
      awvalid[p] <= 1'b1;
      wvalid[p]  <= 1'b1;
      do @(negedge clk); while (!(awready[p] && wready[p]));
      @(posedge clk);
      awvalid[p] <= 1'b0;
      wvalid[p]  <= 1'b0;
      take_response(p, 1'b1);
   endtask

   task automatic read_access(input int p, input logic [11:0] addr);
      pend_addr[p] = addr;
      pend_wr[p]   = 1'b0;
      issued++;
      @(posedge clk);
      araddr[p]  <= addr;
      arvalid[p] <= 1'b1;
      do @(negedge clk); while (!arready[p]);
      @(posedge clk);
      arvalid[p] <= 1'b0;
      take_response(p, 1'b0);
   endtask

   task automatic check_reset_seq();
      for (int j = 0; j <= RST_START + RST_DUR; j++) begin
         @(posedge clk);
         @(negedge clk);
         check_value(sys_rst, (j >= RST_START) && (j < RST_START + RST_DUR), "sys_rst_o");
         if (j < RST_START + RST_DUR) begin
            check_value(any_handshake(), 1'b0, "ready or valid before the pulse ended");
         end
      end
   endtask

   task automatic dual_traffic(input int p);
      logic [11:0] addr;
      for (int i = 0; i < N_DUAL; i++) begin
         addr = (i % 4 == 0) ? SHARED_ADDR : 12'(p * 384 + $urandom_range(383, 0));
         write_access(p, addr, $urandom, 4'($urandom));
         read_access(p, addr);
      end
   endtask

   // Watchdog
   initial begin
      repeat (N_TXN * 20 + 200) @(posedge clk);
      $display("Timeout: run still busy after %0d cycles", N_TXN * 20 + 200);
      $display("Test FAILED");
      $fatal(1, "Timeout");
   end

   initial begin
      logic [11:0] addr;
      void'($urandom(32'hcd66));
      rst_n     = 1'b0;
      stall_max = 0;
      issued    = 0;
      completed = 0;
      for (int p = 0; p < 2; p++) begin
         awaddr[p]  = '0;
         awvalid[p] = 1'b0;
         wdata[p]   = '0;
         wstrb[p]   = '0;
         wvalid[p]  = 1'b0;
         bready[p]  = 1'b0;
         araddr[p]  = '0;
         arvalid[p] = 1'b0;
         rready[p]  = 1'b0;
         pend_wr[p] = 1'b0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // Out of range read parked from the first pulse cycle on
      fork
         check_reset_seq();
         begin
            repeat (RST_START) @(posedge clk);
            read_access(0, 12'hffc);
         end
      join

      for (int i = 0; i < WORDS; i++) begin
         write_access(i % 2, 12'(4 * i), 32'(i) * 32'h9e3779b1, 4'hf);   // Fill pattern
      end

      stall_max = 3;
      for (int i = 0; i < N_SINGLE; i++) begin
         addr = 12'($urandom_range(1023, 0));
         write_access(0, addr, $urandom, 4'hf);
         read_access(0, addr);
      end

      for (int i = 0; i < N_STRB; i++) begin
         write_access(i % 2, 12'h100, $urandom, 4'($urandom));
         read_access(i % 2, 12'h100);
      end

      stall_max = 8;
      fork
         dual_traffic(0);
         dual_traffic(1);
      join

      for (int i = 0; i < N_OOR; i++) begin
         addr = 12'($urandom_range(4095, 1024));
         write_access(i % 2, addr, $urandom, 4'hf);
         read_access(i % 2, addr);
         read_access(i % 2, addr & 12'h3ff);   // Aliased word stays untouched
      end

      stall_max = 2;
      for (int i = 0; i < WORDS; i++) begin
         read_access(i % 2, 12'(4 * i));
      end

      repeat (2) @(posedge clk);
      if (completed == issued) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("Fail at %0t: %0d of %0d transactions completed", $time, completed, issued);
         $display("Test FAILED");
         $fatal(1, "Lost transactions");
      end
   end

endmodule

`default_nettype wire

// File: sources.f
design/axil_pkg.sv
design/soc_cfg_pkg.sv
design/reset_sequencer.sv
design/axil_two_port_arbiter.sv
design/axil_sram.sv
design/soc_mem_top.sv
verification/tb_clock_gen.sv
verification/soc_mem_asserts.sv
verification/tb_soc_mem.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_soc_mem, status taken from the printed result line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
   --top-module tb_soc_mem -f sources.f \
   && ./obj_dir/Vtb_soc_mem | tee /dev/stderr | grep -qx "Test OK" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
